//--- hdl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths.
`define XLEN        32
`define REG_ADDR_W  5

// Bubble word, add x0,x0,x0.
`define NOP_INSTR   32'h0000_0033

// ----------------------------------------
// Major opcodes
// ----------------------------------------
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011

`endif

//--- hdl/rv_pkg.sv
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

	// One instruction word, seen per encoding format.
	typedef union packed {
		struct packed {
			logic [6:0]             funct7;
			logic [`REG_ADDR_W-1:0] rs2;
			logic [`REG_ADDR_W-1:0] rs1;
			logic [2:0]             funct3;
			logic [`REG_ADDR_W-1:0] rd;
			logic [6:0]             opcode;
		} r_fmt;
		struct packed {
			logic [11:0]            imm;
			logic [`REG_ADDR_W-1:0] rs1;
			logic [2:0]             funct3;
			logic [`REG_ADDR_W-1:0] rd;
			logic [6:0]             opcode;
		} i_fmt;
		struct packed {
			logic                   imm12;
			logic [5:0]             imm10_5;
			logic [`REG_ADDR_W-1:0] rs2;
			logic [`REG_ADDR_W-1:0] rs1;
			logic [2:0]             funct3;
			logic [3:0]             imm4_1;
			logic                   imm11;
			logic [6:0]             opcode;
		} b_fmt;
		struct packed {
			logic [19:0]            imm;
			logic [`REG_ADDR_W-1:0] rd;
			logic [6:0]             opcode;
		} u_fmt;
	} instr_t;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLT    = 4'd5,
		ALU_SLL    = 4'd6,
		ALU_SRL    = 4'd7,
		ALU_PASS_B = 4'd8
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_NONE   = 2'd0,
		FWD_EX     = 2'd1, // Result of the instruction in ID/EX.
		FWD_RETIRE = 2'd2
	} fwd_sel_e;

endpackage

`default_nettype wire

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_regfile (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic [`REG_ADDR_W-1:0] raddr_a,
	input  wire logic [`REG_ADDR_W-1:0] raddr_b,
	output logic      [`XLEN-1:0]       rdata_a,
	output logic      [`XLEN-1:0]       rdata_b,
	input  wire logic                   we,
	input  wire logic [`REG_ADDR_W-1:0] waddr,
	input  wire logic [`XLEN-1:0]       wdata
);

	logic [`XLEN-1:0] regs [31:1]; // No storage for x0.

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Asynchronous reads, no write bypass.
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_decode (
	input  wire rv_pkg::instr_t         instr,
	input  wire logic [`XLEN-1:0]       pc,
	input  wire logic [`XLEN-1:0]       rf_rdata_a,
	input  wire logic [`XLEN-1:0]       rf_rdata_b,
	input  wire logic [`XLEN-1:0]       ex_result,
	input  wire logic [`XLEN-1:0]       retire_wdata,
	input  wire rv_pkg::fwd_sel_e       fwd_a,
	input  wire rv_pkg::fwd_sel_e       fwd_b,
	output logic      [`REG_ADDR_W-1:0] rs1,
	output logic      [`REG_ADDR_W-1:0] rs2,
	output logic      [`XLEN-1:0]       porta,
	output logic      [`XLEN-1:0]       portb,
	output rv_pkg::alu_op_e             alu_op,
	output logic                        we,
	output logic      [`REG_ADDR_W-1:0] waddr,
	output logic                        is_branch,
	output logic                        branch_ne,
	output logic      [`XLEN-1:0]       branch_offset,
	output logic                        illegal
);

	logic [6:0]       opcode;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_u;

	assign opcode = instr.r_fmt.opcode;
	assign imm_i  = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
	assign imm_u  = {instr.u_fmt.imm, 12'b0};
	assign branch_offset = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
		instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};

	// Source fields only where the format has them.
	always_comb begin
		rs1 = '0;
		rs2 = '0;
		case (opcode)
			`OPC_OP: begin
				rs1 = instr.r_fmt.rs1;
				rs2 = instr.r_fmt.rs2;
			end
			`OPC_BRANCH: begin
				rs1 = instr.b_fmt.rs1;
				rs2 = instr.b_fmt.rs2;
			end
			`OPC_OP_IMM: rs1 = instr.i_fmt.rs1;
			default: ;
		endcase
	end

	// ----------------------------------------
	// Operand forwarding
	// ----------------------------------------
	always_comb begin
		case (fwd_a)
			rv_pkg::FWD_EX:     rs1_val = ex_result;
			rv_pkg::FWD_RETIRE: rs1_val = retire_wdata;
			default:            rs1_val = rf_rdata_a;
		endcase
		case (fwd_b)
			rv_pkg::FWD_EX:     rs2_val = ex_result;
			rv_pkg::FWD_RETIRE: rs2_val = retire_wdata;
			default:            rs2_val = rf_rdata_b;
		endcase
	end

	always_comb begin
		porta     = rs1_val;
		portb     = rs2_val;
		alu_op    = rv_pkg::ALU_ADD;
		we        = 1'b0;
		waddr     = '0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		illegal   = 1'b0;
		case (opcode)
			`OPC_OP: begin
				we    = 1'b1;
				waddr = instr.r_fmt.rd;
				case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
					10'b0000000_000: alu_op = rv_pkg::ALU_ADD;
					10'b0100000_000: alu_op = rv_pkg::ALU_SUB;
					10'b0000000_001: alu_op = rv_pkg::ALU_SLL;
					10'b0000000_010: alu_op = rv_pkg::ALU_SLT;
					10'b0000000_100: alu_op = rv_pkg::ALU_XOR;
					10'b0000000_101: alu_op = rv_pkg::ALU_SRL;
					10'b0000000_110: alu_op = rv_pkg::ALU_OR;
					10'b0000000_111: alu_op = rv_pkg::ALU_AND;
					default:         illegal = 1'b1; // SRA, SLTU and the rest.
				endcase
			end
			`OPC_OP_IMM: begin
				we    = 1'b1;
				waddr = instr.i_fmt.rd;
				portb = imm_i;
				case (instr.i_fmt.funct3)
					3'b000:  alu_op = rv_pkg::ALU_ADD;
					3'b010:  alu_op = rv_pkg::ALU_SLT;
					3'b100:  alu_op = rv_pkg::ALU_XOR;
					3'b110:  alu_op = rv_pkg::ALU_OR;
					3'b111:  alu_op = rv_pkg::ALU_AND;
					default: illegal = 1'b1; // Shifts by immediate are not supported.
				endcase
			end
			`OPC_LUI: begin
				we     = 1'b1;
				waddr  = instr.u_fmt.rd;
				porta  = '0;
				portb  = imm_u;
				alu_op = rv_pkg::ALU_PASS_B;
			end
			`OPC_BRANCH: begin
				is_branch = 1'b1;
				alu_op    = rv_pkg::ALU_SUB;
				case (instr.b_fmt.funct3)
					3'b000:  branch_ne = 1'b0;
					3'b001:  branch_ne = 1'b1;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase
		// Misaligned fetch is folded into the illegal flag.
		if (pc[1:0] != 2'b00) begin
			illegal = 1'b1;
		end
		if (illegal) begin
			we        = 1'b0;
			is_branch = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/rv_idex_register.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_idex_register (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   stall,
	input  wire logic                   flush,
	input  wire logic                   id_valid,
	input  wire logic [`XLEN-1:0]       id_pc,
	input  wire logic [`XLEN-1:0]       id_instruction,
	input  wire logic [`XLEN-1:0]       id_porta,
	input  wire logic [`XLEN-1:0]       id_portb,
	input  wire rv_pkg::alu_op_e        id_alu_op,
	input  wire logic                   id_we,
	input  wire logic [`REG_ADDR_W-1:0] id_waddr,
	input  wire logic                   id_is_branch,
	input  wire logic                   id_branch_ne,
	input  wire logic [`XLEN-1:0]       id_branch_offset,
	input  wire logic                   id_illegal,
	output logic                        ex_valid,
	output logic      [`XLEN-1:0]       ex_pc,
	output logic      [`XLEN-1:0]       ex_instruction,
	output logic      [`XLEN-1:0]       ex_porta,
	output logic      [`XLEN-1:0]       ex_portb,
	output rv_pkg::alu_op_e             ex_alu_op,
	output logic                        ex_we,
	output logic      [`REG_ADDR_W-1:0] ex_waddr,
	output logic                        ex_is_branch,
	output logic                        ex_branch_ne,
	output logic      [`XLEN-1:0]       ex_branch_offset,
	output logic                        ex_illegal
);

	always_ff @(posedge clk) begin
		if (reset || flush) begin // Bubble.
			ex_valid         <= 1'b0;
			ex_pc            <= '0;
			ex_instruction   <= `NOP_INSTR;
			ex_porta         <= '0;
			ex_portb         <= '0;
			ex_alu_op        <= rv_pkg::ALU_ADD;
			ex_we            <= 1'b0;
			ex_waddr         <= '0;
			ex_is_branch     <= 1'b0;
			ex_branch_ne     <= 1'b0;
			ex_branch_offset <= '0;
			ex_illegal       <= 1'b0;
		end else if (!stall) begin
			ex_valid         <= id_valid;
			ex_pc            <= id_pc;
			ex_instruction   <= id_instruction;
			ex_porta         <= id_porta;
			ex_portb         <= id_portb;
			ex_alu_op        <= id_alu_op;
			ex_we            <= id_we;
			ex_waddr         <= id_waddr;
			ex_is_branch     <= id_is_branch;
			ex_branch_ne     <= id_branch_ne;
			ex_branch_offset <= id_branch_offset;
			ex_illegal       <= id_illegal;
		end
	end

	// The instruction behind a taken branch never reaches execute.
	a_flush_kills: assert property (@(posedge clk) disable iff (reset)
		flush |=> !ex_valid)
		else $error("Error %0t: ex_valid high after flush.", $time);

endmodule

`default_nettype wire

//--- hdl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_execute (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   stall,
	input  wire logic                   ex_valid,
	input  wire logic [`XLEN-1:0]       ex_pc,
	input  wire logic [`XLEN-1:0]       ex_porta,
	input  wire logic [`XLEN-1:0]       ex_portb,
	input  wire rv_pkg::alu_op_e        ex_alu_op,
	input  wire logic                   ex_we,
	input  wire logic [`REG_ADDR_W-1:0] ex_waddr,
	input  wire logic                   ex_is_branch,
	input  wire logic                   ex_branch_ne,
	input  wire logic [`XLEN-1:0]       ex_branch_offset,
	input  wire logic                   ex_illegal,
	output logic      [`XLEN-1:0]       ex_result,
	output logic                        redirect_valid,
	output logic      [`XLEN-1:0]       redirect_pc,
	output logic                        retire_valid,
	output logic      [`XLEN-1:0]       retire_pc,
	output logic                        retire_we,
	output logic      [`REG_ADDR_W-1:0] retire_waddr,
	output logic      [`XLEN-1:0]       retire_wdata,
	output logic                        retire_illegal
);

	logic taken;

	// ----------------------------------------
	// ALU and branch resolution
	// ----------------------------------------
	always_comb begin
		case (ex_alu_op)
			rv_pkg::ALU_SUB:    ex_result = ex_porta - ex_portb;
			rv_pkg::ALU_AND:    ex_result = ex_porta & ex_portb;
			rv_pkg::ALU_OR:     ex_result = ex_porta | ex_portb;
			rv_pkg::ALU_XOR:    ex_result = ex_porta ^ ex_portb;
			rv_pkg::ALU_SLT:    ex_result = {{(`XLEN-1){1'b0}},
				$signed(ex_porta) < $signed(ex_portb)};
			rv_pkg::ALU_SLL:    ex_result = ex_porta << ex_portb[4:0];
			rv_pkg::ALU_SRL:    ex_result = ex_porta >> ex_portb[4:0];
			rv_pkg::ALU_PASS_B: ex_result = ex_portb; // LUI.
			default:            ex_result = ex_porta + ex_portb;
		endcase
	end

	assign taken          = (ex_porta == ex_portb) ^ ex_branch_ne;
	assign redirect_valid = ex_valid && ex_is_branch && taken && !stall;
	assign redirect_pc    = ex_pc + ex_branch_offset;

	// ----------------------------------------
	// Retire register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			retire_valid   <= 1'b0;
			retire_we      <= 1'b0;
			retire_illegal <= 1'b0;
		end else if (!stall) begin
			retire_valid   <= ex_valid;
			retire_we      <= ex_valid && ex_we && !ex_illegal;
			retire_illegal <= ex_valid && ex_illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			retire_pc    <= ex_pc;
			retire_waddr <= ex_waddr;
			retire_wdata <= ex_result;
		end
	end

	a_retire_hold: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable({retire_valid, retire_pc, retire_we, retire_waddr,
			retire_wdata, retire_illegal}))
		else $error("Error %0t: retire outputs moved during a stall.", $time);

	// Fetch must not be redirected while the front end is frozen.
	a_no_redirect_stall: assert property (@(posedge clk) disable iff (reset)
		!(redirect_valid && stall))
		else $error("Error %0t: redirect raised during a stall.", $time);

endmodule

`default_nettype wire

//--- hdl/rv_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_hazard_unit (
	input  wire logic                   retire_valid,
	input  wire logic                   retire_ready,
	input  wire logic                   redirect_valid,
	input  wire logic [`REG_ADDR_W-1:0] rs1,
	input  wire logic [`REG_ADDR_W-1:0] rs2,
	input  wire logic                   ex_valid,
	input  wire logic                   ex_we,
	input  wire logic [`REG_ADDR_W-1:0] ex_waddr,
	input  wire logic                   retire_we,
	input  wire logic [`REG_ADDR_W-1:0] retire_waddr,
	output logic                        stall,
	output logic                        flush,
	output logic                        instr_ready,
	output rv_pkg::fwd_sel_e            fwd_a,
	output rv_pkg::fwd_sel_e            fwd_b
);

	logic ex_writes;
	logic retire_writes;

	function automatic rv_pkg::fwd_sel_e pick_source(input logic [`REG_ADDR_W-1:0] rs);
		if (rs == '0) begin
			return rv_pkg::FWD_NONE;
		end else if (ex_writes && ex_waddr == rs) begin
			return rv_pkg::FWD_EX; // Youngest producer wins.
		end else if (retire_writes && retire_waddr == rs) begin
			return rv_pkg::FWD_RETIRE;
		end
		return rv_pkg::FWD_NONE;
	endfunction

	assign stall       = retire_valid && !retire_ready;
	assign flush       = redirect_valid;
	assign instr_ready = !stall;

	assign ex_writes     = ex_valid && ex_we && (ex_waddr != '0);
	assign retire_writes = retire_valid && retire_we && (retire_waddr != '0);

	always_comb begin
		fwd_a = pick_source(rs1);
		fwd_b = pick_source(rs2);
	end

endmodule

`default_nettype wire

//--- hdl/rv_core_slice.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_core_slice (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   instr_valid,
	input  wire logic [`XLEN-1:0]       instr,
	input  wire logic [`XLEN-1:0]       pc,
	output logic                        instr_ready,
	output logic                        redirect_valid,
	output logic      [`XLEN-1:0]       redirect_pc,
	output logic                        retire_valid,
	output logic      [`XLEN-1:0]       retire_pc,
	output logic                        retire_we,
	output logic      [`REG_ADDR_W-1:0] retire_waddr,
	output logic      [`XLEN-1:0]       retire_wdata,
	output logic                        retire_illegal,
	input  wire logic                   retire_ready
);

	logic                   stall;
	logic                   flush;
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic [`XLEN-1:0]       rf_rdata_a;
	logic [`XLEN-1:0]       rf_rdata_b;
	rv_pkg::fwd_sel_e       fwd_a;
	rv_pkg::fwd_sel_e       fwd_b;

	// Decode outputs.
	logic [`XLEN-1:0]       id_porta;
	logic [`XLEN-1:0]       id_portb;
	rv_pkg::alu_op_e        id_alu_op;
	logic                   id_we;
	logic [`REG_ADDR_W-1:0] id_waddr;
	logic                   id_is_branch;
	logic                   id_branch_ne;
	logic [`XLEN-1:0]       id_branch_offset;
	logic                   id_illegal;

	// ID/EX outputs.
	logic                   ex_valid;
	logic [`XLEN-1:0]       ex_pc;
	logic [`XLEN-1:0]       ex_porta;
	logic [`XLEN-1:0]       ex_portb;
	rv_pkg::alu_op_e        ex_alu_op;
	logic                   ex_we;
	logic [`REG_ADDR_W-1:0] ex_waddr;
	logic                   ex_is_branch;
	logic                   ex_branch_ne;
	logic [`XLEN-1:0]       ex_branch_offset;
	logic                   ex_illegal;
	logic [`XLEN-1:0]       ex_result;

	// A held beat rewrites the same value until it transfers.
	rv_regfile u_regfile (
		.clk     (clk),
		.reset   (reset),
		.raddr_a (rs1),
		.raddr_b (rs2),
		.rdata_a (rf_rdata_a),
		.rdata_b (rf_rdata_b),
		.we      (retire_we),
		.waddr   (retire_waddr),
		.wdata   (retire_wdata)
	);

	rv_decode u_decode (
		.instr         (instr),
		.pc            (pc),
		.rf_rdata_a    (rf_rdata_a),
		.rf_rdata_b    (rf_rdata_b),
		.ex_result     (ex_result),
		.retire_wdata  (retire_wdata),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.rs1           (rs1),
		.rs2           (rs2),
		.porta         (id_porta),
		.portb         (id_portb),
		.alu_op        (id_alu_op),
		.we            (id_we),
		.waddr         (id_waddr),
		.is_branch     (id_is_branch),
		.branch_ne     (id_branch_ne),
		.branch_offset (id_branch_offset),
		.illegal       (id_illegal)
	);

	rv_idex_register u_idex (
		.clk              (clk),
		.reset            (reset),
		.stall            (stall),
		.flush            (flush),
		.id_valid         (instr_valid),
		.id_pc            (pc),
		.id_instruction   (instr),
		.id_porta         (id_porta),
		.id_portb         (id_portb),
		.id_alu_op        (id_alu_op),
		.id_we            (id_we),
		.id_waddr         (id_waddr),
		.id_is_branch     (id_is_branch),
		.id_branch_ne     (id_branch_ne),
		.id_branch_offset (id_branch_offset),
		.id_illegal       (id_illegal),
		.ex_valid         (ex_valid),
		.ex_pc            (ex_pc),
		.ex_instruction   (),
		.ex_porta         (ex_porta),
		.ex_portb         (ex_portb),
		.ex_alu_op        (ex_alu_op),
		.ex_we            (ex_we),
		.ex_waddr         (ex_waddr),
		.ex_is_branch     (ex_is_branch),
		.ex_branch_ne     (ex_branch_ne),
		.ex_branch_offset (ex_branch_offset),
		.ex_illegal       (ex_illegal)
	);

	rv_execute u_execute (
		.clk              (clk),
		.reset            (reset),
		.stall            (stall),
		.ex_valid         (ex_valid),
		.ex_pc            (ex_pc),
		.ex_porta         (ex_porta),
		.ex_portb         (ex_portb),
		.ex_alu_op        (ex_alu_op),
		.ex_we            (ex_we),
		.ex_waddr         (ex_waddr),
		.ex_is_branch     (ex_is_branch),
		.ex_branch_ne     (ex_branch_ne),
		.ex_branch_offset (ex_branch_offset),
		.ex_illegal       (ex_illegal),
		.ex_result        (ex_result),
		.redirect_valid   (redirect_valid),
		.redirect_pc      (redirect_pc),
		.retire_valid     (retire_valid),
		.retire_pc        (retire_pc),
		.retire_we        (retire_we),
		.retire_waddr     (retire_waddr),
		.retire_wdata     (retire_wdata),
		.retire_illegal   (retire_illegal)
	);

	rv_hazard_unit u_hazard (
		.retire_valid   (retire_valid),
		.retire_ready   (retire_ready),
		.redirect_valid (redirect_valid),
		.rs1            (rs1),
		.rs2            (rs2),
		.ex_valid       (ex_valid),
		.ex_we          (ex_we),
		.ex_waddr       (ex_waddr),
		.retire_we      (retire_we),
		.retire_waddr   (retire_waddr),
		.stall          (stall),
		.flush          (flush),
		.instr_ready    (instr_ready),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b)
	);

endmodule

`default_nettype wire

//--- bench/tb_rv_core_slice.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module tb_rv_core_slice;

	typedef struct packed {
		logic [31:0] pc;
		logic        we;
		logic [4:0]  waddr;
		logic [31:0] wdata;
		logic        illegal;
	} beat_t;

	logic        clk;
	logic        reset;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        instr_ready;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic        retire_we;
	logic [4:0]  retire_waddr;
	logic [31:0] retire_wdata;
	logic        retire_illegal;
	logic        retire_ready;

	logic [31:0] mregs [0:31]; // Reference register file.
	beat_t       q[$];
	beat_t       head;
	logic        head_ok;
	logic        xfer;
	logic        bp_on;
	logic        squash_next;
	logic        redirect_allowed;
	logic [31:0] redirect_target;
	logic [31:0] cur_pc;
	int          errors;
	int          beats;
	int          cycles;

	rv_core_slice u_dut (
		.clk            (clk),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.pc             (pc),
		.instr_ready    (instr_ready),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_we      (retire_we),
		.retire_waddr   (retire_waddr),
		.retire_wdata   (retire_wdata),
		.retire_illegal (retire_illegal),
		.retire_ready   (retire_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	a_reset_state: assert property (@(posedge clk)
		reset |=> (!retire_valid && !redirect_valid && instr_ready))
		else begin
			$display("Error %0t: wrong output state around reset.", $time);
			errors++;
		end

	a_beat: assert property (@(posedge clk) disable iff (reset)
		(retire_valid && retire_ready) |-> (head_ok && retire_pc == head.pc
			&& retire_we == head.we && retire_illegal == head.illegal
			&& (!head.we || (retire_waddr == head.waddr && retire_wdata == head.wdata))))
		else begin
			$display("Error %0t: retire beat pc %h wdata %h, expected pc %h wdata %h.",
				$time, retire_pc, retire_wdata, head.pc, head.wdata);
			errors++;
		end

	a_redirect: assert property (@(posedge clk) disable iff (reset)
		redirect_valid |-> (redirect_allowed && redirect_pc == redirect_target
			&& !(retire_valid && !retire_ready)))
		else begin
			$display("Error %0t: redirect to %h is not expected.", $time, redirect_pc);
			errors++;
		end

	a_ready: assert property (@(posedge clk) disable iff (reset)
		instr_ready == !(retire_valid && !retire_ready))
		else begin
			$display("Error %0t: instr_ready does not follow back-pressure.", $time);
			errors++;
		end

	a_hold: assert property (@(posedge clk) disable iff (reset)
		(retire_valid && !retire_ready) |=> (retire_valid && $stable({retire_pc,
			retire_we, retire_waddr, retire_wdata, retire_illegal})))
		else begin
			$display("Error %0t: held retire beat changed.", $time);
			errors++;
		end

	always @(negedge clk) begin
		if (xfer) begin
			q.delete(0);
			beats++;
		end
		head_ok = (q.size() != 0);
		if (head_ok) head = q[0];
		xfer = !reset && retire_valid && retire_ready;
	end

	always @(posedge clk) begin
		retire_ready <= bp_on ? ($urandom % 3 != 0) : 1'b1;
		cycles++;
		if (cycles >= 4000) begin
			$display("Timeout after %0d cycles, the pipeline stopped retiring.", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// Encoders and reference model
	// ----------------------------------------
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, `OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, `OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] enc_b(input logic ne, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], `OPC_BRANCH};
	endfunction

	function automatic logic [31:0] rand_alu();
		logic [2:0] r_f3 [7];
		logic [2:0] i_f3 [5];
		logic [2:0] f3;
		r_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};
		i_f3 = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7};
		case ($urandom % 3)
			0: begin
				f3 = r_f3[$urandom % 7];
				return enc_r((f3 == 3'd0 && $urandom % 2) ? 7'b0100000 : 7'b0, f3,
					$urandom % 8, $urandom % 8, $urandom % 8);
			end
			1: return enc_i(i_f3[$urandom % 5], $urandom % 8, $urandom % 8, $urandom);
			default: return {20'($urandom), 5'($urandom % 8), `OPC_LUI};
		endcase
	endfunction

	task automatic model_exec(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		beat_t       bt;
		a   = mregs[w[19:15]];
		b   = mregs[w[24:20]];
		imm = {{20{w[31]}}, w[31:20]};
		bt  = '{pc: cur_pc, we: 1'b1, waddr: w[11:7], wdata: '0, illegal: 1'b0};
		redirect_allowed = 1'b0;
		case (w[6:0])
			`OPC_OP: case ({w[31:25], w[14:12]})
				10'b0000000_000: bt.wdata = a + b;
				10'b0100000_000: bt.wdata = a - b;
				10'b0000000_001: bt.wdata = a << b[4:0];
				10'b0000000_010: bt.wdata = {31'b0, $signed(a) < $signed(b)};
				10'b0000000_100: bt.wdata = a ^ b;
				10'b0000000_101: bt.wdata = a >> b[4:0];
				10'b0000000_110: bt.wdata = a | b;
				10'b0000000_111: bt.wdata = a & b;
				default:         bt.illegal = 1'b1;
			endcase
			`OPC_OP_IMM: case (w[14:12])
				3'b000:  bt.wdata = a + imm;
				3'b010:  bt.wdata = {31'b0, $signed(a) < $signed(imm)};
				3'b100:  bt.wdata = a ^ imm;
				3'b110:  bt.wdata = a | imm;
				3'b111:  bt.wdata = a & imm;
				default: bt.illegal = 1'b1;
			endcase
			`OPC_LUI: bt.wdata = {w[31:12], 12'b0};
			`OPC_BRANCH: begin
				bt.we = 1'b0;
				if (w[14:13] != 2'b00) begin
					bt.illegal = 1'b1;
				end else if ((a == b) ^ w[12]) begin // Taken.
					squash_next      = 1'b1;
					redirect_allowed = 1'b1;
					redirect_target  = cur_pc + {{19{w[31]}}, w[31], w[7], w[30:25],
						w[11:8], 1'b0};
				end
			end
			default: bt.illegal = 1'b1;
		endcase
		if (bt.illegal) bt.we = 1'b0;
		if (bt.we && bt.waddr != 5'd0) mregs[bt.waddr] = bt.wdata;
		q.push_back(bt);
		cur_pc += 4;
	endtask

	// Offers one word until it is accepted, replaying it after a flushed slot.
	task automatic offer(input logic [31:0] w);
		logic done;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (!squash_next && $urandom % 6 == 0) begin
				instr_valid <= 1'b0;
				@(posedge clk);
			end
			instr_valid <= 1'b1;
			instr       <= w;
			pc          <= cur_pc;
			@(negedge clk);
			while (!instr_ready) begin
				@(posedge clk);
				@(negedge clk);
			end
			if (squash_next) begin
				squash_next = 1'b0;
				cur_pc      = redirect_target;
			end else begin
				model_exec(w);
				done = 1'b1;
			end
		end
	endtask

	task automatic run_mix(input string name, input int n, input int br_pct,
		input int ill_pct);
		int e0;
		int r;
		logic [31:0] ill [4];
		ill = '{32'h0000_2003, enc_r(7'b0100000, 3'd5, 5'd3, 5'd1, 5'd2),
			enc_i(3'd1, 5'd4, 5'd1, 12'd3), enc_b(1'b0, 5'd1, 5'd2, 13'd8) | 32'h4000};
		e0 = errors;
		for (int i = 0; i < n; i++) begin
			r = $urandom % 100;
			if (r < br_pct) begin
				offer(enc_b($urandom % 2, $urandom % 4, $urandom % 4,
					13'(($urandom % 16 + 1) * 4 * (($urandom % 2) ? 1 : -1))));
			end else if (r < br_pct + ill_pct) begin
				offer(ill[$urandom % 4]);
			end else begin
				offer(rand_alu());
			end
		end
		$display("test %s: %0d instructions, %0d errors", name, n, errors - e0);
	endtask

	initial begin
		int e0;
		void'($urandom(23));
		reset        = 1'b1;
		instr_valid  = 1'b0;
		instr        = `NOP_INSTR;
		pc           = '0;
		retire_ready = 1'b1;
		bp_on        = 1'b0;
		squash_next  = 1'b0;
		redirect_allowed = 1'b0;
		redirect_target  = '0;
		cur_pc       = 32'h0000_1000;
		errors       = 0;
		beats        = 0;
		cycles       = 0;
		xfer         = 1'b0;
		head_ok      = 1'b0;
		for (int i = 0; i < 32; i++) mregs[i] = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);
		$display("test reset: %0d errors", errors);
		run_mix("alu", 200, 0, 0);
		e0 = errors;
		offer(enc_i(3'd0, 5'd0, 5'd0, 12'h123)); // Write to x0.
		offer(enc_r(7'b0, 3'd0, 5'd1, 5'd0, 5'd0));
		offer(enc_i(3'd6, 5'd2, 5'd0, 12'h055));
		$display("test x0: 3 instructions, %0d errors", errors - e0);
		run_mix("branch", 200, 30, 0);
		bp_on = 1'b1;
		run_mix("backpressure", 250, 20, 5);
		run_mix("illegal", 100, 10, 30);
		@(posedge clk);
		instr_valid <= 1'b0;
		while (q.size() != 0) @(negedge clk);
		repeat (4) @(posedge clk);
		$display("done: %0d beats checked, %0d errors", beats, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_idex_register.sv
hdl/rv_execute.sv
hdl/rv_hazard_unit.sv
hdl/rv_core_slice.sv
bench/tb_rv_core_slice.sv
